// ==== flist.f ====
+incdir+rtl
rtl/dcache_pkg.sv
rtl/dcache_line_store.sv
rtl/dcache_request_arbiter.sv
rtl/dcache_controller.sv
rtl/dcache_top.sv
verification/dcache_asserts.sv
verification/dcache_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the data cache testbench with verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module dcache_tb -o dcache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/dcache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    exit 1
fi
exit 0

// ==== verification/dcache_tb.sv ====
// data cache testbench with clock, reset, memory model, LFSR, compare tasks, directed tests
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_tb import dcache_pkg::*; ();

    localparam int          CLK_PERIOD = 20;
    localparam int          NUM_TESTS  = 6;
    localparam int          WAIT_LIMIT = 100;            // cycles allowed per handshake
    localparam logic [31:0] ADDR_A     = 32'h0000_1234;  // index 0x23, word 1
    localparam logic [31:0] ADDR_B     = 32'h0000_1634;  // same index, other tag
    localparam logic [31:0] ADDR_NC    = 32'h8000_0108;  // non-cacheable, word 2

    logic                          clk_i = 1'b0;
    logic                          rst_ni, ld_req_i, st_req_i, ld_gnt_o, st_gnt_o, ld_rvalid_o;
    logic                          mem_req_o, mem_ack_i, mem_rtrn_vld_i;
    logic [`DCACHE_WORD_WIDTH-1:0] ld_rdata_o;
    cpu_req_t                      ld_data_i, st_data_i;
    mem_req_t                      mem_data_o;
    mem_rtrn_t                     mem_rtrn_i;

    line_t       mem_lines [logic [27:0]]; // sparse backing store keyed by line address
    mem_req_t    mem_log [$];              // every request the memory accepted
    logic [31:0] lfsr_q = 32'h2c68;
    logic [31:0] exp_a8;                   // expected word at ADDR_A + 8
    int          checks, value_errors, proto_errors;

    dcache_top UUT (.*);

    always #(CLK_PERIOD/2) clk_i = ~clk_i;

    // ************************************************************************
    // reference rules
    // ************************************************************************

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1); // right shifting galois step
    endfunction

    // preload rule where each word holds its own address scrambled
    function automatic logic [31:0] rule_word(logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'h5a5a_5a5a;
    endfunction

    function automatic line_t rule_line(logic [31:0] addr);
        line_t l;
        for (int w = 0; w < `DCACHE_WORDS_PER_LINE; w++)
            l[w*32 +: 32] = rule_word({addr[31:4], 4'b0000} + 32'(w*4));
        return l;
    endfunction

    // enabled bytes come from the new word and the rest stay old
    function automatic logic [31:0] word_merge(logic [31:0] old_w, new_w, logic [3:0] be);
        return (old_w & ~{{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}})
             | (new_w &  {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}});
    endfunction

    function automatic mem_req_t exp_req(mem_rtype_e t, logic nc, logic [31:0] a, line_t d,
                                         logic [15:0] be);
        return '{rtype: t, nc: nc, paddr: a, data: d, be: be};
    endfunction

    task automatic draw(int nbits, output int value);
        value = 0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_q = lfsr_step(lfsr_q); // one step per bit
            value  = (value << 1) | int'(lfsr_q[0]);
        end
    endtask

    // ************************************************************************
    // compare tasks
    // ************************************************************************

    task automatic check_word(string name, logic [`DCACHE_WORD_WIDTH-1:0] exp, act);
        checks++;
        if (act !== exp) begin
            value_errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_req(string name, mem_req_t exp, act);
        checks++;
        if (act !== exp) begin
            value_errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_line(string name, line_t exp, act);
        checks++;
        if (act !== exp) begin
            value_errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // ************************************************************************
    // memory model with random ack and return delays of 0 to 3 cycles
    // ************************************************************************

    initial begin : memory_model
        mem_req_t req;
        line_t    cur, rdata;
        int       delay;
        mem_ack_i      <= 1'b0;
        mem_rtrn_vld_i <= 1'b0;
        mem_rtrn_i     <= '0;
        forever begin
            @(negedge clk_i);
            if (mem_req_o) begin
                req = mem_data_o;
                draw(2, delay);
                repeat (delay) @(negedge clk_i);
                @(posedge clk_i) mem_ack_i <= 1'b1;
                @(posedge clk_i) mem_ack_i <= 1'b0;
                mem_log.push_back(req);
                if (mem_lines.exists(req.paddr[31:4])) cur = mem_lines[req.paddr[31:4]];
                else cur = rule_line(req.paddr);
                for (int b = 0; b < 16; b++) begin
                    if (req.rtype == MEM_STORE && req.be[b]) cur[b*8 +: 8] = req.data[b*8 +: 8];
                    // an nc return carries only its own word
                    rdata[b*8 +: 8] = (req.nc && !req.be[b]) ? 8'h00 : cur[b*8 +: 8];
                end
                mem_lines[req.paddr[31:4]] = cur;
                draw(2, delay);
                repeat (delay) @(posedge clk_i);
                mem_rtrn_vld_i <= 1'b1;
                mem_rtrn_i     <= '{rtype: req.rtype, data: rdata};
                @(posedge clk_i) mem_rtrn_vld_i <= 1'b0;
            end
        end
    end

    // ************************************************************************
    // cpu side drivers
    // ************************************************************************

    // lat counts cycles from the grant cycle to ld_rvalid_o
    task automatic do_load(logic [31:0] addr, output logic [31:0] data, output int lat);
        int n;
        @(posedge clk_i);
        ld_req_i  <= 1'b1;
        ld_data_i <= '{addr: addr, wdata: '0, be: '0};
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
        end while (!ld_gnt_o && n < WAIT_LIMIT);
        @(posedge clk_i) ld_req_i <= 1'b0;
        lat = 0;
        do begin
            @(negedge clk_i);
            lat++;
        end while (!ld_rvalid_o && lat < WAIT_LIMIT);
        data = ld_rdata_o;
        if (!ld_rvalid_o) begin
            proto_errors++;
            $display("load from %h got no grant or no data within %0d cycles", addr, WAIT_LIMIT);
        end
    endtask

    task automatic do_store(logic [31:0] addr, logic [31:0] wdata, logic [3:0] be);
        int n;
        @(posedge clk_i);
        st_req_i  <= 1'b1;
        st_data_i <= '{addr: addr, wdata: wdata, be: be};
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
        end while (!st_gnt_o && n < WAIT_LIMIT);
        if (!st_gnt_o) begin
            proto_errors++;
            $display("store to %h was never granted", addr);
        end
        @(posedge clk_i) st_req_i <= 1'b0;
    endtask

    // ************************************************************************
    // directed tests
    // ************************************************************************

    task automatic test_reset();
        check_word("reset: grants, rvalid, mem_req", '0,
                   32'({ld_gnt_o, st_gnt_o, ld_rvalid_o, mem_req_o}));
    endtask

    task automatic test_load_miss_hit();
        logic [31:0] data;
        int          lat;
        mem_log.delete();
        do_load(ADDR_A, data, lat);
        check_word("load_miss_hit: miss data", rule_word(ADDR_A), data);
        check_word("load_miss_hit: miss requests", 1, mem_log.size());
        check_req("load_miss_hit: refill", exp_req(MEM_LOAD, 1'b0, 32'h1230, '0, '1), mem_log[0]);
        do_load(ADDR_A + 4, data, lat);
        check_word("load_miss_hit: hit data", rule_word(ADDR_A + 4), data);
        check_word("load_miss_hit: hit latency", 2, lat);
        check_word("load_miss_hit: hit requests", 1, mem_log.size()); // nothing new
    endtask

    task automatic test_store_hit_merge();
        logic [31:0] data;
        int          lat;
        mem_log.delete();
        exp_a8 = word_merge(rule_word(ADDR_A + 8), 32'hdead_beef, 4'b0101);
        do_store(ADDR_A + 8, 32'hdead_beef, 4'b0101);
        do_load(ADDR_A + 8, data, lat);
        check_word("store_hit_merge: merged word", exp_a8, data);
        check_word("store_hit_merge: requests", 0, mem_log.size());
    endtask

    task automatic test_dirty_eviction();
        logic [31:0] data;
        int          lat;
        line_t       wb_line;
        mem_log.delete();
        wb_line              = rule_line(ADDR_A);
        wb_line[3*32 +: 32]  = exp_a8;          // dirty word from the store hit
        do_load(ADDR_B, data, lat);
        check_word("dirty_eviction: new data", rule_word(ADDR_B), data);
        check_word("dirty_eviction: requests", 2, mem_log.size());
        check_req("dirty_eviction: writeback", exp_req(MEM_STORE, 1'b0, 32'h1230, wb_line, '1),
                  mem_log[0]);
        check_line("dirty_eviction: writeback line", wb_line, mem_log[0].data);
        check_req("dirty_eviction: refill", exp_req(MEM_LOAD, 1'b0, 32'h1630, '0, '1), mem_log[1]);
        mem_log.delete();
        do_load(ADDR_A + 8, data, lat);         // old line comes back from memory
        check_word("dirty_eviction: reloaded word", exp_a8, data);
        check_word("dirty_eviction: reload requests", 1, mem_log.size());
    endtask

    task automatic test_nc_bypass();
        logic [31:0] data;
        int          lat;
        mem_log.delete();
        do_load(ADDR_NC, data, lat);
        check_word("nc_bypass: first load", rule_word(ADDR_NC), data);
        do_store(ADDR_NC, 32'h1122_3344, 4'b0011);
        do_load(ADDR_NC, data, lat);
        check_word("nc_bypass: load after store",
                   word_merge(rule_word(ADDR_NC), 32'h1122_3344, 4'b0011), data);
        check_word("nc_bypass: requests", 3, mem_log.size());
        check_req("nc_bypass: load req", exp_req(MEM_LOAD, 1'b1, ADDR_NC, '0, 16'h0f00), mem_log[0]);
        check_req("nc_bypass: store req", exp_req(MEM_STORE, 1'b1, ADDR_NC,
                  {32'h0, 32'h1122_3344, 64'h0}, 16'h0300), mem_log[1]);
        mem_log.delete();
        do_load(ADDR_A + 8, data, lat);         // cached line untouched by the bypass
        check_word("nc_bypass: cached word", exp_a8, data);
        check_word("nc_bypass: cached latency", 2, lat);
        check_word("nc_bypass: cached requests", 0, mem_log.size());
    endtask

    task automatic test_load_priority();
        logic [31:0] data;
        int          n, lat;
        mem_log.delete();
        data = 'x;
        @(posedge clk_i);
        ld_req_i  <= 1'b1;
        ld_data_i <= '{addr: ADDR_A + 8, wdata: '0, be: '0};
        st_req_i  <= 1'b1;
        st_data_i <= '{addr: ADDR_A + 8, wdata: 32'h0bad_f00d, be: 4'hf};
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
        end while (!ld_gnt_o && !st_gnt_o && n < WAIT_LIMIT);
        check_word("load_priority: first grant", 32'b10, 32'({ld_gnt_o, st_gnt_o}));
        @(posedge clk_i) ld_req_i <= 1'b0;
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
            if (ld_rvalid_o) data = ld_rdata_o; // load completes while the store waits
        end while (!st_gnt_o && n < WAIT_LIMIT);
        check_word("load_priority: store granted", 1, 32'(st_gnt_o));
        @(posedge clk_i) st_req_i <= 1'b0;
        check_word("load_priority: load sees old word", exp_a8, data);
        exp_a8 = 32'h0bad_f00d;
        do_load(ADDR_A + 8, data, lat);
        check_word("load_priority: word after store", exp_a8, data);
        check_word("load_priority: requests", 0, mem_log.size());
    endtask

    // ************************************************************************
    // sequence, watchdog and verdict
    // ************************************************************************

    initial begin : watchdog
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", NUM_TESTS * 200);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        rst_ni    <= 1'b0;
        ld_req_i  <= 1'b0;
        st_req_i  <= 1'b0;
        ld_data_i <= '0;
        st_data_i <= '0;
        repeat (2) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        test_reset();
        test_load_miss_hit();
        test_store_hit_merge();
        test_dirty_eviction();
        test_nc_bypass();
        test_load_priority();
        $display("checks %0d, value errors %0d, protocol errors %0d",
                 checks, value_errors, proto_errors);
        if (value_errors + proto_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== verification/dcache_asserts.sv ====
// concurrent protocol checks on the data cache top-level ports, bound into dcache_top
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_asserts import dcache_pkg::*; (
    input logic     clk_i,
    input logic     rst_ni,
    input logic     ld_req_i,
    input logic     st_req_i,
    input logic     ld_gnt_o,
    input logic     st_gnt_o,
    input logic     mem_req_o,
    input mem_req_t mem_data_o,
    input logic     mem_ack_i
);

    // request and payload held until the ack cycle
    mem_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_data_o))
        else $error("memory request dropped or changed before its ack");

    gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(ld_gnt_o && st_gnt_o))
        else $error("load and store granted in the same cycle");

    ld_gnt_has_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ld_gnt_o |-> ld_req_i)
        else $error("load grant without a load request");

    st_gnt_has_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        st_gnt_o |-> st_req_i)
        else $error("store grant without a store request");

endmodule

bind dcache_top dcache_asserts i_asserts (
    .clk_i, .rst_ni, .ld_req_i, .st_req_i, .ld_gnt_o, .st_gnt_o,
    .mem_req_o, .mem_data_o, .mem_ack_i
);

// ==== rtl/dcache_top.sv ====
// data cache top level with arbiter, controller, tag store and data store
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_top import dcache_pkg::*; (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    // load port
    input  logic                          ld_req_i,
    input  cpu_req_t                      ld_data_i,
    output logic                          ld_gnt_o,
    output logic                          ld_rvalid_o,
    output logic [`DCACHE_WORD_WIDTH-1:0] ld_rdata_o,
    // store port
    input  logic                          st_req_i,
    input  cpu_req_t                      st_data_i,
    output logic                          st_gnt_o,
    // memory port
    output logic                          mem_req_o,
    output mem_req_t                      mem_data_o,
    input  logic                          mem_ack_i,
    input  logic                          mem_rtrn_vld_i,
    input  mem_rtrn_t                     mem_rtrn_i
);

    logic                           idle, accept, req_we;
    cpu_req_t                       req;
    logic                           tag_en, tag_we, line_en, line_we;
    tag_entry_t                     tag_wdata, tag_rdata;
    line_t                          line_wdata, line_rdata;
    logic [`DCACHE_INDEX_WIDTH-1:0] store_addr;

    dcache_request_arbiter i_arbiter (
        .clk_i, .rst_ni,
        .ld_req_i, .ld_data_i, .st_req_i, .st_data_i,
        .idle_i   (idle),
        .ld_gnt_o, .st_gnt_o,
        .accept_o (accept),
        .req_we_o (req_we),
        .req_o    (req)
    );

    dcache_controller i_controller (
        .clk_i, .rst_ni,
        .accept_i     (accept),
        .req_we_i     (req_we),
        .req_i        (req),
        .tag_rdata_i  (tag_rdata),
        .line_rdata_i (line_rdata),
        .mem_ack_i, .mem_rtrn_vld_i, .mem_rtrn_i,
        .idle_o       (idle),
        .ld_rvalid_o, .ld_rdata_o,
        .tag_en_o     (tag_en),
        .tag_we_o     (tag_we),
        .tag_wdata_o  (tag_wdata),
        .line_en_o    (line_en),
        .line_we_o    (line_we),
        .line_wdata_o (line_wdata),
        .store_addr_o (store_addr),
        .mem_req_o, .mem_data_o
    );

    // valid, dirty and tag per line
    dcache_line_store #(.payload_t(tag_entry_t)) i_tag_store (
        .clk_i, .rst_ni,
        .en_i (tag_en), .we_i (tag_we), .addr_i (store_addr),
        .wdata_i (tag_wdata), .rdata_o (tag_rdata)
    );

    // line data
    dcache_line_store #(.payload_t(line_t)) i_data_store (
        .clk_i, .rst_ni,
        .en_i (line_en), .we_i (line_we), .addr_i (store_addr),
        .wdata_i (line_wdata), .rdata_o (line_rdata)
    );

endmodule

// ==== rtl/dcache_controller.sv ====
// cache FSM with hit/miss decision, writeback, refill, bypass and word merge/extract
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_controller import dcache_pkg::*; (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           accept_i,     // new request captured
    input  logic                           req_we_i,     // captured request is a store
    input  cpu_req_t                       req_i,
    input  tag_entry_t                     tag_rdata_i,
    input  line_t                          line_rdata_i,
    input  logic                           mem_ack_i,
    input  logic                           mem_rtrn_vld_i,
    input  mem_rtrn_t                      mem_rtrn_i,
    output logic                           idle_o,
    output logic                           ld_rvalid_o,
    output logic [`DCACHE_WORD_WIDTH-1:0]  ld_rdata_o,
    output logic                           tag_en_o,
    output logic                           tag_we_o,
    output tag_entry_t                     tag_wdata_o,
    output logic                           line_en_o,
    output logic                           line_we_o,
    output line_t                          line_wdata_o,
    output logic [`DCACHE_INDEX_WIDTH-1:0] store_addr_o, // shared by both stores
    output logic                           mem_req_o,
    output mem_req_t                       mem_data_o
);

    localparam int WORD_BYTES = `DCACHE_WORD_WIDTH / 8;
    localparam int LINE_BYTES = `DCACHE_LINE_WIDTH / 8;
    localparam int WOFF_W     = $clog2(`DCACHE_WORDS_PER_LINE); // word select bits

    typedef enum logic [3:0] {
        IDLE, TAG_READ, COMPARE, WB_REQ, WB_WAIT,
        REFILL_REQ, REFILL_WAIT, BYPASS_REQ, BYPASS_WAIT
    } state_e;

    state_e                          state_q, state_d;
    logic [`DCACHE_TAG_WIDTH-1:0]    req_tag;
    logic [WOFF_W-1:0]               req_woff;
    logic [`DCACHE_OFFSET_WIDTH-1:0] line_zero;
    logic                            req_nc, tag_hit;
    logic [`DCACHE_ADDR_WIDTH-1:0]   wb_addr_q, victim_addr;
    line_t                           wb_line_q, victim_line, fill_line;
    logic [WORD_BYTES-1:0]           byp_be;
    mem_req_t                        wb_req, refill_req, bypass_req;

    // byte merge of the store word into a line at its word slot
    function automatic line_t merge_word(line_t line, cpu_req_t req, logic [WOFF_W-1:0] woff);
        line_t merged;
        merged = line;
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (req.be[b]) begin
                merged[woff*`DCACHE_WORD_WIDTH + b*8 +: 8] = req.wdata[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    function automatic logic [`DCACHE_WORD_WIDTH-1:0] get_word(line_t line,
                                                               logic [WOFF_W-1:0] woff);
        return line[woff*`DCACHE_WORD_WIDTH +: `DCACHE_WORD_WIDTH];
    endfunction

    // ************************************************************************
    // address split and hit decision
    // ************************************************************************

    assign req_tag      = req_i.addr[`DCACHE_ADDR_WIDTH-1 -: `DCACHE_TAG_WIDTH];
    assign store_addr_o = req_i.addr[`DCACHE_OFFSET_WIDTH +: `DCACHE_INDEX_WIDTH];
    assign req_woff     = req_i.addr[`DCACHE_OFFSET_WIDTH-1 -: WOFF_W];
    assign line_zero    = '0;
    assign req_nc       = (req_i.addr >= `DCACHE_NC_BASE); // region is the only bypass cause
    assign tag_hit      = tag_rdata_i.valid && (tag_rdata_i.tag == req_tag);
    assign idle_o       = (state_q == IDLE);

    // victim comes straight from the stores in COMPARE, from the copy afterwards
    assign victim_addr = (state_q == COMPARE) ? {tag_rdata_i.tag, store_addr_o, line_zero}
                                              : wb_addr_q;
    assign victim_line = (state_q == COMPARE) ? line_rdata_i : wb_line_q;
    assign fill_line   = req_we_i ? merge_word(mem_rtrn_i.data, req_i, req_woff)
                                  : mem_rtrn_i.data; // write allocate
    assign byp_be      = req_we_i ? req_i.be : '1;   // loads read the whole word

    // the three memory transactions
    assign wb_req     = '{rtype: MEM_STORE, nc: 1'b0, paddr: victim_addr,
                          data: victim_line, be: '1};
    assign refill_req = '{rtype: MEM_LOAD, nc: 1'b0,
                          paddr: {req_tag, store_addr_o, line_zero}, data: '0, be: '1};
    assign bypass_req = '{rtype: req_we_i ? MEM_STORE : MEM_LOAD, nc: 1'b1,
                          paddr: {req_i.addr[`DCACHE_ADDR_WIDTH-1:2], 2'b00},
                          data: line_t'(req_i.wdata) << (req_woff*`DCACHE_WORD_WIDTH),
                          be: LINE_BYTES'(byp_be) << (req_woff*WORD_BYTES)};

    // ************************************************************************
    // state machine
    // ************************************************************************

    always_comb begin
        state_d      = state_q;
        ld_rvalid_o  = 1'b0;
        ld_rdata_o   = '0;
        tag_en_o     = 1'b0;
        tag_we_o     = 1'b0;
        tag_wdata_o  = '{valid: 1'b1, dirty: req_we_i, tag: req_tag};
        line_en_o    = 1'b0;
        line_we_o    = 1'b0;
        line_wdata_o = fill_line;
        mem_req_o    = 1'b0;
        mem_data_o   = refill_req;

        case (state_q)
            IDLE: if (accept_i) state_d = TAG_READ;
            TAG_READ: begin
                tag_en_o  = 1'b1; // read both stores at the registered index
                line_en_o = 1'b1;
                state_d   = COMPARE;
            end
            COMPARE: begin
                if (req_nc) begin
                    mem_req_o  = 1'b1;
                    mem_data_o = bypass_req;
                    state_d    = mem_ack_i ? BYPASS_WAIT : BYPASS_REQ;
                end else if (tag_hit) begin
                    state_d = IDLE;
                    if (req_we_i) begin
                        tag_en_o     = 1'b1; // mark dirty
                        tag_we_o     = 1'b1;
                        line_en_o    = 1'b1;
                        line_we_o    = 1'b1;
                        line_wdata_o = merge_word(line_rdata_i, req_i, req_woff);
                    end else begin
                        ld_rvalid_o = 1'b1;
                        ld_rdata_o  = get_word(line_rdata_i, req_woff);
                    end
                end else if (tag_rdata_i.valid && tag_rdata_i.dirty) begin
                    mem_req_o  = 1'b1;   // write back the victim first
                    mem_data_o = wb_req;
                    state_d    = mem_ack_i ? WB_WAIT : WB_REQ;
                end else begin
                    mem_req_o = 1'b1;    // clean miss, go straight to refill
                    state_d   = mem_ack_i ? REFILL_WAIT : REFILL_REQ;
                end
            end
            WB_REQ: begin
                mem_req_o  = 1'b1;
                mem_data_o = wb_req;
                if (mem_ack_i) state_d = WB_WAIT;
            end
            WB_WAIT: if (mem_rtrn_vld_i && mem_rtrn_i.rtype == MEM_STORE) state_d = REFILL_REQ;
            REFILL_REQ: begin
                mem_req_o = 1'b1;
                if (mem_ack_i) state_d = REFILL_WAIT;
            end
            REFILL_WAIT: begin
                if (mem_rtrn_vld_i && mem_rtrn_i.rtype == MEM_LOAD) begin
                    tag_en_o    = 1'b1; // new tag, dirty only for a store
                    tag_we_o    = 1'b1;
                    line_en_o   = 1'b1;
                    line_we_o   = 1'b1;
                    ld_rvalid_o = !req_we_i;
                    ld_rdata_o  = get_word(mem_rtrn_i.data, req_woff);
                    state_d     = IDLE;
                end
            end
            BYPASS_REQ: begin
                mem_req_o  = 1'b1;
                mem_data_o = bypass_req;
                if (mem_ack_i) state_d = BYPASS_WAIT;
            end
            BYPASS_WAIT: begin
                if (mem_rtrn_vld_i && mem_rtrn_i.rtype == bypass_req.rtype) begin
                    ld_rvalid_o = !req_we_i;
                    ld_rdata_o  = get_word(mem_rtrn_i.data, req_woff);
                    state_d     = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // victim copy, taken before the refill overwrites the line
    always_ff @(posedge clk_i) begin
        if (state_q == COMPARE) begin
            wb_addr_q <= victim_addr;
            wb_line_q <= line_rdata_i;
        end
    end

endmodule

// ==== rtl/dcache_request_arbiter.sv ====
// load-first request selection, port grants and the captured request register
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_request_arbiter import dcache_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     ld_req_i,
    input  cpu_req_t ld_data_i,
    input  logic     st_req_i,
    input  cpu_req_t st_data_i,
    input  logic     idle_i,   // controller can take a new request
    output logic     ld_gnt_o,
    output logic     st_gnt_o,
    output logic     accept_o, // one pulse in the grant cycle
    output logic     req_we_o, // captured request is a store
    output cpu_req_t req_o     // captured request
);

    // load wins when both ports ask in the same cycle
    assign ld_gnt_o = idle_i & ld_req_i;
    assign st_gnt_o = idle_i & st_req_i & ~ld_req_i;
    assign accept_o = ld_gnt_o | st_gnt_o; // idle drops next cycle, so one pulse

    // store flag is control state
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            req_we_o <= 1'b0;
        end else if (accept_o) begin
            req_we_o <= st_gnt_o;
        end
    end

    // request payload, held until the next grant
    always_ff @(posedge clk_i) begin
        if (ld_gnt_o) begin
            req_o <= ld_data_i;
        end else if (st_gnt_o) begin
            req_o <= st_data_i;
        end
    end

endmodule

// ==== rtl/dcache_line_store.sv ====
// synchronous single-port array with type-parameter payload and cleared entries
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_line_store #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = `DCACHE_NUM_LINES
) (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           en_i,    // access this cycle
    input  logic                           we_i,    // write, else read
    input  logic [`DCACHE_INDEX_WIDTH-1:0] addr_i,
    input  payload_t                       wdata_i,
    output payload_t                       rdata_o  // valid the cycle after en_i
);

    payload_t mem_q [DEPTH]; // one entry per line

    // write port, reset wipes every entry so all tags start invalid
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= '0;
            end
        end else if (en_i && we_i) begin
            mem_q[addr_i] <= wdata_i;
        end
    end

    // registered read, holds its value while en_i is low
    // a write cycle returns the old entry
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            rdata_o <= mem_q[addr_i];
        end
    end

endmodule

// ==== rtl/dcache_pkg.sv ====
// cpu request, tag entry, line, memory request and memory return types
`include "dcache_config.svh"

package dcache_pkg;

    // ************************************************************************
    // cpu side
    // ************************************************************************

    // one load or store request, the load port leaves wdata and be unused
    typedef struct packed {
        logic [`DCACHE_ADDR_WIDTH-1:0]   addr;  // byte address
        logic [`DCACHE_WORD_WIDTH-1:0]   wdata; // store data
        logic [`DCACHE_WORD_WIDTH/8-1:0] be;    // store byte enables
    } cpu_req_t;

    // ************************************************************************
    // cache stores
    // ************************************************************************

    typedef struct packed {
        logic                         valid; // line holds data
        logic                         dirty; // line differs from memory
        logic [`DCACHE_TAG_WIDTH-1:0] tag;
    } tag_entry_t;

    typedef logic [`DCACHE_LINE_WIDTH-1:0] line_t; // one full cache line

    // ************************************************************************
    // memory side
    // ************************************************************************

    typedef enum logic {
        MEM_LOAD  = 1'b0, // read request / load ack
        MEM_STORE = 1'b1  // write request / store ack
    } mem_rtype_e;

    // single outstanding memory transaction
    typedef struct packed {
        mem_rtype_e                      rtype;
        logic                            nc;    // word access, not a line
        logic [`DCACHE_ADDR_WIDTH-1:0]   paddr; // line aligned for line transfers
        line_t                           data;  // word sits in its lane for nc
        logic [`DCACHE_LINE_WIDTH/8-1:0] be;    // byte lanes in use
    } mem_req_t;

    // memory return, rtype tells a load ack from a store ack
    typedef struct packed {
        mem_rtype_e rtype;
        line_t      data;
    } mem_rtrn_t;

endpackage

// ==== rtl/dcache_config.svh ====
// data cache geometry, address split and non-cacheable region macros
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// ************************************************************************
// address and word
// ************************************************************************

`define DCACHE_ADDR_WIDTH 32 // physical address bits
`define DCACHE_WORD_WIDTH 32 // cpu word, loads always return a full word

// ************************************************************************
// line geometry
// ************************************************************************

`define DCACHE_WORDS_PER_LINE 4   // words in one line
`define DCACHE_LINE_WIDTH     128 // words per line * word width
`define DCACHE_NUM_LINES      64  // direct mapped, one line per index

// address split: | tag | index | byte offset |
`define DCACHE_OFFSET_WIDTH 4  // byte offset inside a line
`define DCACHE_INDEX_WIDTH  6  // log2 of the number of lines
`define DCACHE_TAG_WIDTH    22 // addr - index - offset

// ************************************************************************
// memory map
// ************************************************************************

// everything from here up bypasses the cache as single-word accesses
`define DCACHE_NC_BASE 32'h8000_0000

`endif
